// File: bench/subsys_stimulus.txt
# name port(c core, h host, pc+ph start together) op(w, r) addr wdata strb exp_rdata exp_err
# all numbers hex, exp_rdata is compared on reads only
tcm_wr0      c  w 00000010 11223344 f 00000000 0
tcm_rd0      c  r 00000010 00000000 0 11223344 0
tcm_strb_lo  h  w 00000010 deadbeef 5 00000000 0
tcm_rd_lo    c  r 00000010 00000000 0 11ad33ef 0
tcm_strb_hi  c  w 00000010 cafe0000 c 00000000 0
tcm_rd_hi    h  r 00000010 00000000 0 cafe33ef 0
tcm_top_wr   h  w 00000ffc 0f1e2d3c f 00000000 0
tcm_top_rd   c  r 00000ffc 00000000 0 0f1e2d3c 0
reg0_wr      h  w 80000000 01234567 f 00000000 0
reg7_wr      h  w 8000001c 89abcdef f 00000000 0
reg3_wr      h  w 8000000c 5a5aa5a5 3 00000000 0
reg0_rd      c  r 80000000 00000000 0 01234567 0
reg7_rd      c  r 8000001c 00000000 0 89abcdef 0
reg3_rd      c  r 8000000c 00000000 0 0000a5a5 0
unmap_rd     c  r 00001000 00000000 0 00000000 1
unmap_wr     h  w 40000000 12345678 f 00000000 1
periph_hi_rd c  r 80000024 00000000 0 00000000 1
console_rd   h  r 80000020 00000000 0 00000000 0
pair_wr_c    pc w 00000100 aaaa5555 f 00000000 0
pair_wr_h    ph w 00000104 5555aaaa f 00000000 0
pair_rd_c    pc r 00000104 00000000 0 5555aaaa 0
pair_rd_h    ph r 00000100 00000000 0 aaaa5555 0
con_r        c  w 80000020 00000052 1 00000000 0
con_v        h  w 80000020 00000056 1 00000000 0
con_3        c  w 80000020 00000033 1 00000000 0
con_2        h  w 80000020 00000032 1 00000000 0

// File: files.f
common/bus_pkg.sv
common/apb_if.sv
rtl/bus_arbiter.sv
rtl/bus_decoder.sv
tcm/tcm_ram.sv
periph/periph_regs.sv
rtl/subsys_top.sv
bench/bus_checker.sv
bench/tb_subsys.sv

// File: Bender.yml
package:
  name: subsys

sources:
  - files:
      - common/bus_pkg.sv
      - common/apb_if.sv
      - rtl/bus_arbiter.sv
      - rtl/bus_decoder.sv
      - tcm/tcm_ram.sv
      - periph/periph_regs.sv
      - rtl/subsys_top.sv
  - target: test
    files:
      - bench/bus_checker.sv
      - bench/tb_subsys.sv

// File: bench/tb_subsys.sv
`timescale 1ns/1ps

module tb_subsys;

    localparam time clk_period      = 100;
    localparam int  reset_cycles    = 5;
    localparam int  cycles_per_line = 20;    // generous for a transfer that loses arbitration.
    localparam int  timeout_margin  = 100;

    logic clk = 1'b0;
    logic rst_n;

    // index 0 is the core port, index 1 the host port.
    logic [1:0][bus_pkg::addr_w-1:0] paddr;
    logic [1:0]                      psel;
    logic [1:0]                      penable;
    logic [1:0]                      pwrite;
    logic [1:0][bus_pkg::data_w-1:0] pwdata;
    logic [1:0][bus_pkg::strb_w-1:0] pstrb;
    wire  [1:0][bus_pkg::data_w-1:0] prdata;
    wire  [1:0]                      pready;
    wire  [1:0]                      pslverr;
    wire  [7:0]                      console_char;
    wire                             console_valid;

    string       lines[$];      // stimulus lines, comments dropped.
    bit          loaded;
    int unsigned tb_errors;
    int unsigned total_errors;
    int          i;

    always #(clk_period / 2) clk = ~clk;

    //////////////////////////////////////////////////
    // DUT and checker
    //////////////////////////////////////////////////

    subsys_top i_subsys_top (
        .clk           (clk),
        .rst_n         (rst_n),
        .core_paddr    (paddr[0]),
        .core_psel     (psel[0]),
        .core_penable  (penable[0]),
        .core_pwrite   (pwrite[0]),
        .core_pwdata   (pwdata[0]),
        .core_pstrb    (pstrb[0]),
        .core_prdata   (prdata[0]),
        .core_pready   (pready[0]),
        .core_pslverr  (pslverr[0]),
        .host_paddr    (paddr[1]),
        .host_psel     (psel[1]),
        .host_penable  (penable[1]),
        .host_pwrite   (pwrite[1]),
        .host_pwdata   (pwdata[1]),
        .host_pstrb    (pstrb[1]),
        .host_prdata   (prdata[1]),
        .host_pready   (pready[1]),
        .host_pslverr  (pslverr[1]),
        .console_char  (console_char),
        .console_valid (console_valid)
    );

    bus_checker i_bus_checker (
        .clk           (clk),
        .rst_n         (rst_n),
        .core_psel     (psel[0]),
        .core_penable  (penable[0]),
        .core_pready   (pready[0]),
        .core_prdata   (prdata[0]),
        .core_pslverr  (pslverr[0]),
        .host_psel     (psel[1]),
        .host_penable  (penable[1]),
        .host_pready   (pready[1]),
        .host_prdata   (prdata[1]),
        .host_pslverr  (pslverr[1]),
        .console_char  (console_char),
        .console_valid (console_valid)
    );

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////

    task automatic load_stimulus;
        int    fd;
        string line;
        fd = $fopen("bench/subsys_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file bench/subsys_stimulus.txt");
            tb_errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                if ($fgets(line, fd) > 0 && line.len() > 1 && line.getc(0) != "#") begin
                    lines.push_back(line);
                end
            end
            $fclose(fd);
        end
    endtask

    function automatic bit is_paired(input string line);
        string name;
        string port;
        int    n;
        n = $sscanf(line, "%s %s", name, port);
        return (n == 2) && (port.getc(0) == "p");
    endfunction

    // one APB transfer on the port named in the line, ends after that port's pready.
    task automatic run_line(input string line);
        string                      name;
        string                      port;
        string                      op;
        logic [bus_pkg::addr_w-1:0] addr;
        logic [bus_pkg::data_w-1:0] wdata;
        logic [bus_pkg::data_w-1:0] rdata;
        logic [bus_pkg::strb_w-1:0] strb;
        logic                       err;
        int                         n;
        int                         p;
        logic                       wr;
        n = $sscanf(line, "%s %s %s %h %h %h %h %h",
                    name, port, op, addr, wdata, strb, rdata, err);
        if (n != 8) begin
            $display("stimulus line could not be read: %s", line);
            tb_errors++;
        end else begin
            p  = (port.getc(port.len() - 1) == "h") ? 1 : 0;
            wr = (op == "w");
            i_bus_checker.expect_transfer(p, name, !wr, rdata, err);
            if (wr && addr == bus_pkg::console_addr) begin
                i_bus_checker.expect_char(name, wdata[7:0]);
            end
            @(negedge clk);                     // setup phase.
            paddr[p]   = addr;
            pwrite[p]  = wr;
            pwdata[p]  = wdata;
            pstrb[p]   = strb;
            psel[p]    = 1'b1;
            penable[p] = 1'b0;
            @(negedge clk);
            penable[p] = 1'b1;
            while (pready[p] !== 1'b1) begin
                @(negedge clk);
            end
            @(negedge clk);                     // transfer ended on the edge before.
            psel[p]    = 1'b0;
            penable[p] = 1'b0;
        end
    endtask

    initial begin
        rst_n   = 1'b0;
        paddr   = '0;
        psel    = '0;
        penable = '0;
        pwrite  = '0;
        pwdata  = '0;
        pstrb   = '0;
        load_stimulus();
        if (lines.size() == 0) begin
            $display("the stimulus file holds no transfers");
            tb_errors++;
        end
        loaded = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        i = 0;
        while (i < lines.size()) begin
            if (is_paired(lines[i]) && i + 1 < lines.size()) begin
                fork
                    run_line(lines[i]);
                    run_line(lines[i + 1]);
                join
                i += 2;
            end else begin
                run_line(lines[i]);
                i += 1;
            end
        end

        repeat (4) @(negedge clk);              // let the last console pulse through.
        i_bus_checker.report_leftovers();
        total_errors = tb_errors + i_bus_checker.errors;
        $display("run finished with %0d errors", total_errors);
        if (total_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // watchdog, scaled by the number of transfers.
    initial begin
        wait (loaded);
        repeat (lines.size() * cycles_per_line + timeout_margin) @(posedge clk);
        $display("the run timed out, a transfer never completed");
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// File: bench/bus_checker.sv
`timescale 1ns/1ps

module bus_checker (
    input logic                       clk,
    input logic                       rst_n,
    input logic                       core_psel,
    input logic                       core_penable,
    input logic                       core_pready,
    input logic [bus_pkg::data_w-1:0] core_prdata,
    input logic                       core_pslverr,
    input logic                       host_psel,
    input logic                       host_penable,
    input logic                       host_pready,
    input logic [bus_pkg::data_w-1:0] host_prdata,
    input logic                       host_pslverr,
    input logic [7:0]                 console_char,
    input logic                       console_valid
);

    typedef struct packed {
        logic                       rd;
        logic [bus_pkg::data_w-1:0] data;
        logic                       err;
    } exp_t;

    exp_t        core_q[$];
    exp_t        host_q[$];
    string       core_names[$];
    string       host_names[$];
    logic [7:0]  con_q[$];
    string       con_names[$];
    int unsigned errors;
    bit          reset_seen;
    int unsigned post_reset;    // edges checked since reset went away.

    task automatic expect_transfer(input int port, input string name, input logic rd,
                                   input logic [bus_pkg::data_w-1:0] data, input logic err);
        exp_t e;
        e.rd   = rd;
        e.data = data;
        e.err  = err;
        if (port == 0) begin
            core_q.push_back(e);
            core_names.push_back(name);
        end else begin
            host_q.push_back(e);
            host_names.push_back(name);
        end
    endtask

    task automatic expect_char(input string name, input logic [7:0] ch);
        con_q.push_back(ch);
        con_names.push_back(name);
    endtask

    //////////////////////////////////////////////////
    // comparing
    //////////////////////////////////////////////////

    task automatic retire(input int port, input logic [bus_pkg::data_w-1:0] rdata,
                          input logic err);
        string name;
        exp_t  e;
        bit    found;
        found = 1'b0;
        if (port == 0 && core_q.size() > 0) begin
            name  = core_names.pop_front();
            e     = core_q.pop_front();
            found = 1'b1;
        end else if (port == 1 && host_q.size() > 0) begin
            name  = host_names.pop_front();
            e     = host_q.pop_front();
            found = 1'b1;
        end
        if (!found) begin
            $display("the %s port finished a transfer that no stimulus line started",
                     port ? "host" : "core");
            errors++;
        end else begin
            if (err !== e.err) begin
                $display("[ERROR] %s: expected pslverr %0b, got %0b", name, e.err, err);
                errors++;
            end
            if (e.rd && rdata !== e.data) begin
                $display("[ERROR] %s: expected prdata %h, got %h", name, e.data, rdata);
                errors++;
            end
        end
    endtask

    task automatic check_char(input logic [7:0] ch);
        string      name;
        logic [7:0] exp_ch;
        if (con_q.size() == 0) begin
            $display("the console printed %h while no character was expected", ch);
            errors++;
        end else begin
            name   = con_names.pop_front();
            exp_ch = con_q.pop_front();
            if (ch !== exp_ch) begin
                $display("[ERROR] %s: expected console char %h, got %h", name, exp_ch, ch);
                errors++;
            end
        end
    endtask

    always @(posedge clk) begin
        if (core_psel && core_penable && core_pready) begin
            retire(0, core_prdata, core_pslverr);
        end
        if (host_psel && host_penable && host_pready) begin
            retire(1, host_prdata, host_pslverr);
        end
        if (console_valid) begin
            check_char(console_char);
        end
    end

    // outputs stay quiet in reset and on the first edges after it.
    always @(posedge clk) begin
        if (reset_seen && post_reset < 2) begin
            if ({core_pready, host_pready, console_valid} !== 3'b000) begin
                $display("[ERROR] reset_idle: expected 000, got %b",
                         {core_pready, host_pready, console_valid});
                errors++;
            end
        end
        if (!rst_n) begin
            reset_seen = 1'b1;
            post_reset = 0;
        end else if (reset_seen && post_reset < 2) begin
            post_reset++;
        end
    end

    task automatic report_leftovers;
        if (core_q.size() > 0) begin
            $display("%0d core transfers were expected but never completed", core_q.size());
            errors++;
        end
        if (host_q.size() > 0) begin
            $display("%0d host transfers were expected but never completed", host_q.size());
            errors++;
        end
        if (con_q.size() > 0) begin
            $display("%0d console characters were expected but never printed", con_q.size());
            errors++;
        end
    endtask

endmodule

// File: rtl/subsys_top.sv
`timescale 1ns/1ps

module subsys_top (
    input  logic                       clk,
    input  logic                       rst_n,
    // core load/store port.
    input  logic [bus_pkg::addr_w-1:0] core_paddr,
    input  logic                       core_psel,
    input  logic                       core_penable,
    input  logic                       core_pwrite,
    input  logic [bus_pkg::data_w-1:0] core_pwdata,
    input  logic [bus_pkg::strb_w-1:0] core_pstrb,
    output logic [bus_pkg::data_w-1:0] core_prdata,
    output logic                       core_pready,
    output logic                       core_pslverr,
    // host debug port.
    input  logic [bus_pkg::addr_w-1:0] host_paddr,
    input  logic                       host_psel,
    input  logic                       host_penable,
    input  logic                       host_pwrite,
    input  logic [bus_pkg::data_w-1:0] host_pwdata,
    input  logic [bus_pkg::strb_w-1:0] host_pstrb,
    output logic [bus_pkg::data_w-1:0] host_prdata,
    output logic                       host_pready,
    output logic                       host_pslverr,
    // console character output.
    output logic [7:0]                 console_char,
    output logic                       console_valid
);

    apb_if core_bus ();
    apb_if host_bus ();
    apb_if shared_bus ();
    apb_if tcm_bus ();
    apb_if periph_bus ();

    //////////////////////////////////////////////////
    // plain ports onto the internal buses
    //////////////////////////////////////////////////

    assign core_bus.paddr   = core_paddr;
    assign core_bus.psel    = core_psel;
    assign core_bus.penable = core_penable;
    assign core_bus.pwrite  = core_pwrite;
    assign core_bus.pwdata  = core_pwdata;
    assign core_bus.pstrb   = core_pstrb;
    assign core_prdata      = core_bus.prdata;
    assign core_pready      = core_bus.pready;
    assign core_pslverr     = core_bus.pslverr;

    assign host_bus.paddr   = host_paddr;
    assign host_bus.psel    = host_psel;
    assign host_bus.penable = host_penable;
    assign host_bus.pwrite  = host_pwrite;
    assign host_bus.pwdata  = host_pwdata;
    assign host_bus.pstrb   = host_pstrb;
    assign host_prdata      = host_bus.prdata;
    assign host_pready      = host_bus.pready;
    assign host_pslverr     = host_bus.pslverr;

    //////////////////////////////////////////////////
    // blocks
    //////////////////////////////////////////////////

    bus_arbiter i_bus_arbiter (
        .clk      (clk),
        .rst_n    (rst_n),
        .req_core (core_bus.completer),
        .req_host (host_bus.completer),
        .bus      (shared_bus.requester)
    );

    bus_decoder i_bus_decoder (
        .bus    (shared_bus.completer),
        .tcm    (tcm_bus.requester),
        .periph (periph_bus.requester)
    );

    tcm_ram i_tcm_ram (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (tcm_bus.completer)
    );

    periph_regs i_periph_regs (
        .clk           (clk),
        .rst_n         (rst_n),
        .bus           (periph_bus.completer),
        .console_char  (console_char),
        .console_valid (console_valid)
    );

endmodule

// File: periph/periph_regs.sv
`timescale 1ns/1ps

module periph_regs (
    input  logic       clk,
    input  logic       rst_n,
    apb_if.completer   bus,
    output logic [7:0] console_char,
    output logic       console_valid
);

    logic [bus_pkg::data_w-1:0]    regs [bus_pkg::num_regs];
    logic [bus_pkg::addr_w-1:0]    offset;
    logic [bus_pkg::reg_idx_w-1:0] idx;
    logic                          is_reg;
    logic                          is_con;
    logic                          access;

    //////////////////////////////////////////////////
    // decode inside the window
    //////////////////////////////////////////////////

    assign offset = bus.paddr - bus_pkg::periph_base;
    assign idx    = offset[bus_pkg::reg_idx_w+1:2];
    assign is_reg = offset < (bus_pkg::console_addr - bus_pkg::periph_base);
    assign is_con = (bus.paddr == bus_pkg::console_addr);
    assign access = bus.psel && bus.penable;

    // general registers, byte writable.
    always_ff @(posedge clk) begin
        if ( !rst_n ) begin
            for (int r = 0; r < bus_pkg::num_regs; r++) begin
                regs[r] <= '0;
            end
        end else if ( access && bus.pwrite && is_reg ) begin
            for (int b = 0; b < bus_pkg::strb_w; b++) begin
                if ( bus.pstrb[b] ) begin
                    regs[idx][8*b +: 8] <= bus.pwdata[8*b +: 8];
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // console
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if ( !rst_n ) begin
            console_valid <= 1'b0;
        end else begin
            console_valid <= access && bus.pwrite && is_con;   // one cycle pulse.
        end
    end

    always_ff @(posedge clk) begin
        if ( access && bus.pwrite && is_con ) begin
            console_char <= bus.pwdata[7:0];
        end
    end

    // no wait states here. the console reads as zero.
    assign bus.pready  = access;
    assign bus.prdata  = is_reg ? regs[idx] : '0;
    assign bus.pslverr = !is_reg && !is_con;

    // every transfer through the arbiter takes at least three cycles.
    assert property (@(posedge clk) disable iff (!rst_n)
        console_valid |=> !console_valid);

endmodule

// File: tcm/tcm_ram.sv
`timescale 1ns/1ps

module tcm_ram (
    input  logic     clk,
    input  logic     rst_n,
    apb_if.completer bus
);

    logic [bus_pkg::data_w-1:0]    mem [bus_pkg::tcm_words];
    logic [bus_pkg::tcm_idx_w-1:0] idx;
    logic [bus_pkg::data_w-1:0]    rdata;
    logic                          rd_done;    // read word is waiting in rdata.
    logic                          access;

    assign idx    = bus.paddr[bus_pkg::tcm_idx_w+1:2];
    assign access = bus.psel && bus.penable;

    //////////////////////////////////////////////////
    // storage
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if ( access && bus.pwrite ) begin
            for (int b = 0; b < bus_pkg::strb_w; b++) begin
                if ( bus.pstrb[b] ) begin
                    mem[idx][8*b +: 8] <= bus.pwdata[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if ( access && !bus.pwrite && !rd_done ) begin
            rdata <= mem[idx];
        end
    end

    //////////////////////////////////////////////////
    // read wait state
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if ( !rst_n ) begin
            rd_done <= 1'b0;
        end else if ( access && !bus.pwrite ) begin
            rd_done <= !rd_done;    // set on the first cycle, cleared when done.
        end else begin
            rd_done <= 1'b0;
        end
    end

    assign bus.pready  = access && (bus.pwrite || rd_done);
    assign bus.prdata  = rdata;
    assign bus.pslverr = 1'b0;

    // ready only inside an access phase, and a read never on its first cycle.
    assert property (@(posedge clk) disable iff (!rst_n)
        bus.pready |-> bus.psel && bus.penable &&
                       (bus.pwrite || $past(bus.psel && bus.penable)));

endmodule

// File: rtl/bus_decoder.sv
`timescale 1ns/1ps

module bus_decoder (
    apb_if.completer bus,
    apb_if.requester tcm,
    apb_if.requester periph
);

    logic hit_tcm;
    logic hit_periph;

    //////////////////////////////////////////////////
    // address decode
    //////////////////////////////////////////////////

    assign hit_tcm    = (bus.paddr >= bus_pkg::tcm_base) &&
                        (bus.paddr <= bus_pkg::tcm_last);
    assign hit_periph = (bus.paddr >= bus_pkg::periph_base) &&
                        (bus.paddr <= bus_pkg::periph_last);

    // request side goes to both targets, only psel is steered.
    assign tcm.psel    = bus.psel && hit_tcm;
    assign tcm.penable = bus.penable;
    assign tcm.paddr   = bus.paddr;
    assign tcm.pwrite  = bus.pwrite;
    assign tcm.pwdata  = bus.pwdata;
    assign tcm.pstrb   = bus.pstrb;

    assign periph.psel    = bus.psel && hit_periph;
    assign periph.penable = bus.penable;
    assign periph.paddr   = bus.paddr;
    assign periph.pwrite  = bus.pwrite;
    assign periph.pwdata  = bus.pwdata;
    assign periph.pstrb   = bus.pstrb;

    //////////////////////////////////////////////////
    // response mux
    //////////////////////////////////////////////////

    always_comb begin
        if ( hit_tcm ) begin
            bus.prdata  = tcm.prdata;
            bus.pready  = tcm.pready;
            bus.pslverr = tcm.pslverr;
        end else if ( hit_periph ) begin
            bus.prdata  = periph.prdata;
            bus.pready  = periph.pready;
            bus.pslverr = periph.pslverr;
        end else begin
            bus.prdata  = '0;       // unmapped, answered here without wait.
            bus.pready  = 1'b1;
            bus.pslverr = 1'b1;
        end
    end

    // checked once per transfer, where the access phase starts.
    assert property (@(posedge bus.penable)
        $onehot0({tcm.psel, periph.psel}));

endmodule

// File: rtl/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter (
    input  logic     clk,
    input  logic     rst_n,
    apb_if.completer req_core,
    apb_if.completer req_host,
    apb_if.requester bus
);

    typedef enum logic [1:0] {
        st_idle,
        st_setup,
        st_access
    } state_t;

    state_t state;
    logic   grant_host;     // 1 when the host port owns the shared bus.
    logic   last_host;      // 1 when the host was served last.
    logic   pick_host;

    // on a tie the port that was not served last wins.
    assign pick_host = req_host.psel && (!req_core.psel || !last_host);

    //////////////////////////////////////////////////
    // grant and phase control
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if ( !rst_n ) begin
            state      <= st_idle;
            grant_host <= 1'b0;
            last_host  <= 1'b0;
        end else begin
            case ( state )
                st_idle: begin
                    if ( req_core.psel || req_host.psel ) begin
                        grant_host <= pick_host;
                        state      <= st_setup;
                    end
                end
                st_setup: state <= st_access;   // one setup cycle on the shared bus.
                st_access: begin
                    if ( bus.pready ) begin
                        last_host <= grant_host;
                        state     <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // shared bus and responses
    //////////////////////////////////////////////////

    assign bus.psel    = (state != st_idle);
    assign bus.penable = (state == st_access);
    assign bus.paddr   = grant_host ? req_host.paddr  : req_core.paddr;
    assign bus.pwrite  = grant_host ? req_host.pwrite : req_core.pwrite;
    assign bus.pwdata  = grant_host ? req_host.pwdata : req_core.pwdata;
    assign bus.pstrb   = grant_host ? req_host.pstrb  : req_core.pstrb;

    // the loser keeps seeing pready low and simply waits.
    assign req_core.pready  = bus.penable && !grant_host && bus.pready;
    assign req_host.pready  = bus.penable &&  grant_host && bus.pready;
    assign req_core.pslverr = !grant_host && bus.pslverr;
    assign req_host.pslverr =  grant_host && bus.pslverr;
    assign req_core.prdata  = bus.prdata;
    assign req_host.prdata  = bus.prdata;

    // every access phase is preceded by exactly one setup cycle.
    assert property (@(posedge clk) disable iff (!rst_n)
        $rose(bus.penable) |-> $past(bus.psel && !bus.penable));

    // ownership is fixed for the whole transfer.
    assert property (@(posedge clk) disable iff (!rst_n)
        (bus.psel && $past(bus.psel)) |-> $stable(grant_host));

endmodule

// File: common/apb_if.sv
`timescale 1ns/1ps

// one APB transfer path, the same width everywhere in the subsystem.
interface apb_if;

    // requester side.
    logic [bus_pkg::addr_w-1:0] paddr;
    logic                       psel;
    logic                       penable;
    logic                       pwrite;
    logic [bus_pkg::data_w-1:0] pwdata;
    logic [bus_pkg::strb_w-1:0] pstrb;

    // completer side.
    logic [bus_pkg::data_w-1:0] prdata;
    logic                       pready;
    logic                       pslverr;

    modport requester (
        output paddr, psel, penable, pwrite, pwdata, pstrb,
        input  prdata, pready, pslverr
    );

    modport completer (
        input  paddr, psel, penable, pwrite, pwdata, pstrb,
        output prdata, pready, pslverr
    );

endinterface

// File: common/bus_pkg.sv
package bus_pkg;

    //////////////////////////////////////////////////
    // bus widths
    //////////////////////////////////////////////////

    localparam int unsigned addr_w = 32;            // byte address.
    localparam int unsigned data_w = 32;            // one word per transfer.
    localparam int unsigned strb_w = data_w / 8;    // one strobe per byte.

    //////////////////////////////////////////////////
    // address map
    //////////////////////////////////////////////////

    // tightly coupled memory, word addressed inside its window.
    localparam int unsigned tcm_words = 1024;
    localparam int unsigned tcm_idx_w = $clog2(tcm_words);

    localparam logic [addr_w-1:0] tcm_base = 32'h0000_0000;
    localparam logic [addr_w-1:0] tcm_last = 32'h0000_0FFF;

    // peripheral window, general registers first, console right after.
    localparam logic [addr_w-1:0] periph_base = 32'h8000_0000;
    localparam logic [addr_w-1:0] periph_last = 32'h8000_0FFF;

    localparam int unsigned num_regs  = 8;
    localparam int unsigned reg_idx_w = $clog2(num_regs);

    // a byte written here shows up on the console output.
    localparam logic [addr_w-1:0] console_addr = 32'h8000_0020;

endpackage
